// File: include/evo_params.svh
`ifndef EVO_PARAMS_SVH
`define EVO_PARAMS_SVH

// circuit shape
`define EVO_IN_BITS 8 // input bits, nodes 0..7
`define EVO_OUT_BITS 8 // output bits, taken from the last genes
`define EVO_NUM_GENES 16 // two-input gates in the network

// gene word fields
`define EVO_SRC_BITS 5 // node index width, 32 addressable nodes
`define EVO_OP_BITS 3 // gate opcode width
`define EVO_GENE_BITS 16 // one raw gene word

// sample stream
`define EVO_BUF_DEPTH 4 // fifo entries, same as sender credits

// error counters
`define EVO_SUM_BITS 16 // per output bit

`endif

// File: design/evo_pkg.sv
`default_nettype none

`include "evo_params.svh"

package evo_pkg;

	typedef enum logic [`EVO_OP_BITS-1:0] {
		opAnd, // 0
		opOr,
		opXor,
		opNand,
		opNor,
		opXnor,
		opNotA, // ignores srcB
		opPassA // ignores srcB
	} geneOp_e;

	typedef struct packed {
		geneOp_e op; // top bits of the word
		logic [`EVO_SRC_BITS-1:0] srcA;
		logic [`EVO_SRC_BITS-1:0] srcB;
		logic [`EVO_GENE_BITS-`EVO_OP_BITS-2*`EVO_SRC_BITS-1:0] spare; // unused low bits
	} geneWord_t;

	typedef struct packed {
		geneOp_e op;
		logic [`EVO_SRC_BITS-1:0] srcA;
		logic [`EVO_SRC_BITS-1:0] srcB;
		logic srcAOk; // srcA points at a lower node
		logic srcBOk;
	} gene_t;

	typedef geneWord_t [`EVO_NUM_GENES-1:0] chrom_t; // gene 0 in the low word

	typedef struct packed {
		logic [`EVO_IN_BITS-1:0] inSeq; // circuit input
		logic [`EVO_OUT_BITS-1:0] expected; // wanted output
		logic [`EVO_OUT_BITS-1:0] validMask; // bits that count
		logic last; // closes the run
	} sample_t;

	typedef logic [`EVO_OUT_BITS-1:0][`EVO_SUM_BITS-1:0] errorSums_t; // index = output bit

endpackage

`default_nettype wire

// File: design/sampleBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module sampleBuffer (
	input logic clk,
	input logic rst,
	input logic sampleValid, // sender spent a credit
	input evo_pkg::sample_t sampleIn,
	output logic popValid,
	output evo_pkg::sample_t popSample,
	output logic creditReturn // one pulse per pop
);
	import evo_pkg::*;

	localparam int Depth = `EVO_BUF_DEPTH;
	localparam int PtrBits = $clog2(Depth);
	localparam int CntBits = $clog2(Depth + 1);

	sample_t mem [Depth]; // circular storage
	logic [PtrBits-1:0] wrPtr;
	logic [PtrBits-1:0] rdPtr;
	logic [CntBits-1:0] count; // occupancy
	logic pop;

	assign pop = (count != '0); // drain whenever something is held

	always_ff @(posedge clk) begin
		if (sampleValid) begin
			mem[wrPtr] <= sampleIn;
		end
		if (pop) begin
			popSample <= mem[rdPtr]; // head goes out with popValid
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			popValid <= 1'b0;
			creditReturn <= 1'b0;
		end else begin
			popValid <= pop;
			creditReturn <= pop; // credit back in the pop cycle
			if (sampleValid) begin
				wrPtr <= (wrPtr == PtrBits'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PtrBits'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({sampleValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or write+pop
			endcase
		end
	end

	// sender must never write into a full fifo
	creditOverflow: assert property (@(posedge clk) disable iff (rst)
		!(sampleValid && count == CntBits'(Depth)))
		else $error("sampleBuffer write while full, credit violation");

endmodule

`default_nettype wire

// File: design/chromDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module chromDecode (
	input logic clk,
	input logic rst,
	input logic start, // latch a new chromosome
	input evo_pkg::chrom_t chrom,
	output evo_pkg::gene_t [`EVO_NUM_GENES-1:0] genes
);
	import evo_pkg::*;

	localparam int NumNodes = `EVO_IN_BITS + `EVO_NUM_GENES; // 24 real nodes

	gene_t [`EVO_NUM_GENES-1:0] decoded;

	// a source must sit below the gene's own node
	always_comb begin
		for (int k = 0; k < `EVO_NUM_GENES; k++) begin
			decoded[k].op = chrom[k].op;
			decoded[k].srcA = chrom[k].srcA;
			decoded[k].srcB = chrom[k].srcB;
			decoded[k].srcAOk = (int'(chrom[k].srcA) < `EVO_IN_BITS + k) &&
				(int'(chrom[k].srcA) < NumNodes); // 24..31 read zero
			decoded[k].srcBOk = (int'(chrom[k].srcB) < `EVO_IN_BITS + k) &&
				(int'(chrom[k].srcB) < NumNodes);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `EVO_NUM_GENES; k++) begin
				// all-zero gene word as decoded, node 0 is a legal source
				genes[k] <= '{op: opAnd, srcA: '0, srcB: '0, srcAOk: 1'b1, srcBOk: 1'b1};
			end
		end else if (start) begin
			genes <= decoded; // held until next start
		end
	end

endmodule

`default_nettype wire

// File: design/circuitEval.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module circuitEval (
	input logic clk,
	input logic rst,
	input logic inValid,
	input evo_pkg::sample_t inSample,
	input evo_pkg::gene_t [`EVO_NUM_GENES-1:0] genes,
	output logic outValid,
	output evo_pkg::sample_t outSample,
	output logic [`EVO_OUT_BITS-1:0] circuitOut
);
	import evo_pkg::*;

	localparam int NodeSpace = 1 << `EVO_SRC_BITS; // every index a source can name
	localparam int FirstOut = `EVO_NUM_GENES - `EVO_OUT_BITS; // first output gene
	localparam int LowNodes = `EVO_IN_BITS + FirstOut; // nodes kept after stage one

	typedef logic [NodeSpace-1:0] nodeVec_t;

	function automatic logic gateOut(input geneOp_e op, input logic a, input logic b);
		case (op)
			opAnd: gateOut = a & b;
			opOr: gateOut = a | b;
			opXor: gateOut = a ^ b;
			opNand: gateOut = ~(a & b);
			opNor: gateOut = ~(a | b);
			opXnor: gateOut = ~(a ^ b);
			opNotA: gateOut = ~a;
			default: gateOut = a; // pass A
		endcase
	endfunction

	// genes lo..hi-1 in order, each may read anything below it
	function automatic nodeVec_t evalGenes(input nodeVec_t base,
			input gene_t [`EVO_NUM_GENES-1:0] g, input int lo, input int hi);
		nodeVec_t n;
		logic a;
		logic b;
		n = base;
		for (int k = lo; k < hi; k++) begin
			a = g[k].srcAOk ? n[g[k].srcA] : 1'b0; // bad source reads 0
			b = g[k].srcBOk ? n[g[k].srcB] : 1'b0;
			n[`EVO_IN_BITS + k] = gateOut(g[k].op, a, b);
		end
		return n;
	endfunction

	nodeVec_t stageOneNodes;
	nodeVec_t stageTwoNodes;
	logic [LowNodes-1:0] lowNodes; // inputs plus gates 0..7
	logic s1Valid;
	sample_t s1Sample;

	always_comb begin
		stageOneNodes = evalGenes(nodeVec_t'(inSample.inSeq), genes, 0, FirstOut);
		stageTwoNodes = evalGenes(nodeVec_t'(lowNodes), genes, FirstOut, `EVO_NUM_GENES);
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			lowNodes <= stageOneNodes[LowNodes-1:0];
			s1Sample <= inSample;
		end
		if (s1Valid) begin
			circuitOut <= stageTwoNodes[LowNodes +: `EVO_OUT_BITS]; // nodes 16..23
			outSample <= s1Sample;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid <= 1'b0;
			outValid <= 1'b0;
		end else begin
			s1Valid <= inValid;
			outValid <= s1Valid;
		end
	end

	evalLatency: assert property (@(posedge clk) disable iff (rst)
		outValid == $past(inValid, 2))
		else $error("circuitEval outValid not two cycles after inValid");

endmodule

`default_nettype wire

// File: design/errorAccum.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module errorAccum (
	input logic clk,
	input logic rst,
	input logic start, // new run, clear sums
	input logic resValid,
	input evo_pkg::sample_t resSample,
	input logic [`EVO_OUT_BITS-1:0] circuitOut,
	output evo_pkg::errorSums_t errorSums,
	output logic done
);
	import evo_pkg::*;

	logic [`EVO_OUT_BITS-1:0] mismatch;
	logic lastAcc; // last sample just added

	assign mismatch = (circuitOut ^ resSample.expected) & resSample.validMask;

	always_ff @(posedge clk) begin
		if (rst) begin
			errorSums <= '0;
			lastAcc <= 1'b0;
			done <= 1'b0;
		end else begin
			lastAcc <= resValid && resSample.last;
			done <= lastAcc; // sums already final here
			if (start) begin
				errorSums <= '0;
			end else if (resValid) begin
				for (int b = 0; b < `EVO_OUT_BITS; b++) begin
					errorSums[b] <= errorSums[b] + `EVO_SUM_BITS'(mismatch[b]);
				end
			end
		end
	end

	// one last sample per run gives a single-cycle done
	donePulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("errorAccum done high two cycles in a row");

endmodule

`default_nettype wire

// File: design/evolveEvalTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module evolveEvalTop (
	input logic clk,
	input logic rst,
	input logic start, // only while idle
	input evo_pkg::chrom_t chrom,
	input logic sampleValid,
	input evo_pkg::sample_t sampleIn,
	output logic creditReturn,
	output evo_pkg::errorSums_t errorSums,
	output logic done
);
	import evo_pkg::*;

	logic popValid; // fifo head
	sample_t popSample;
	gene_t [`EVO_NUM_GENES-1:0] genes; // decoded chromosome
	logic evalValid; // pipeline result
	sample_t evalSample;
	logic [`EVO_OUT_BITS-1:0] circuitOut;

	sampleBuffer u_sampleBuffer (
		.clk(clk),
		.rst(rst),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.popValid(popValid),
		.popSample(popSample),
		.creditReturn(creditReturn)
	);

	chromDecode u_chromDecode (
		.clk(clk),
		.rst(rst),
		.start(start),
		.chrom(chrom),
		.genes(genes)
	);

	circuitEval u_circuitEval (
		.clk(clk),
		.rst(rst),
		.inValid(popValid),
		.inSample(popSample),
		.genes(genes),
		.outValid(evalValid),
		.outSample(evalSample),
		.circuitOut(circuitOut)
	);

	errorAccum u_errorAccum (
		.clk(clk),
		.rst(rst),
		.start(start),
		.resValid(evalValid),
		.resSample(evalSample),
		.circuitOut(circuitOut),
		.errorSums(errorSums),
		.done(done)
	);

endmodule

`default_nettype wire

// File: tests/tb_evolveEvalTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "evo_params.svh"

module tb_evolveEvalTop;
	import evo_pkg::*;

	localparam int Depth = `EVO_BUF_DEPTH; // sender credits after reset
	localparam int WaitLimit = 200; // cycles per wait

	logic clk;
	logic rst;
	logic start;
	chrom_t chrom;
	logic sampleValid;
	sample_t sampleIn;
	logic creditReturn;
	errorSums_t errorSums;
	logic done;

	int seed = 45565;
	int credits; // sender side credit count
	int sentTotal;
	int returnedTotal;
	int errCount = 0;
	int testCount = 0;
	chrom_t modelChrom; // chromosome the model runs
	errorSums_t expSums; // model sums of the current run
	errorSums_t maskTally; // set mask bits per output bit

	evolveEvalTop u_evolveEvalTop (
		.clk(clk),
		.rst(rst),
		.start(start),
		.chrom(chrom),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.creditReturn(creditReturn),
		.errorSums(errorSums),
		.done(done)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		if (rst) begin
			credits <= Depth;
			sentTotal <= 0;
			returnedTotal <= 0;
		end else begin
			credits <= credits - int'(sampleValid) + int'(creditReturn);
			sentTotal <= sentTotal + int'(sampleValid);
			returnedTotal <= returnedTotal + int'(creditReturn);
		end
	end

	sumsMatch: assert property (@(posedge clk) disable iff (rst) done |-> errorSums == expSums)
		else begin
			errCount++;
			$display("CHECK FAILED at %0t: errorSums got %h expected %h", $time,
				$sampled(errorSums), $sampled(expSums));
		end

	creditRange: assert property (@(posedge clk) disable iff (rst)
		credits >= 0 && credits <= Depth)
		else begin
			errCount++;
			$display("credit counter left its range at %0t: %0d", $time, $sampled(credits));
		end

	creditQuiet: assert property (@(posedge clk) $fell(rst) |-> !creditReturn)
		else begin
			errCount++;
			$display("CHECK FAILED at %0t: creditReturn got %b expected 0", $time,
				$sampled(creditReturn));
		end

	// nodes 0..7 inputs, node 8+k gene k, sources at or above own node read 0
	function automatic logic [`EVO_OUT_BITS-1:0] modelOut(input chrom_t c,
			input logic [`EVO_IN_BITS-1:0] x);
		logic [31:0] node;
		logic a;
		logic b;
		node = 32'(x);
		for (int k = 0; k < `EVO_NUM_GENES; k++) begin
			a = (int'(c[k].srcA) < 8 + k) ? node[c[k].srcA] : 1'b0;
			b = (int'(c[k].srcB) < 8 + k) ? node[c[k].srcB] : 1'b0;
			case (int'(c[k].op))
				0: node[8 + k] = a & b;
				1: node[8 + k] = a | b;
				2: node[8 + k] = a ^ b;
				3: node[8 + k] = ~(a & b);
				4: node[8 + k] = ~(a | b);
				5: node[8 + k] = ~(a ^ b);
				6: node[8 + k] = ~a; // B unused
				default: node[8 + k] = a;
			endcase
		end
		return node[23:16]; // outputs are genes 8..15
	endfunction

	function automatic chrom_t gateBank(input geneOp_e op);
		chrom_t c;
		c = '0;
		for (int b = 0; b < `EVO_OUT_BITS; b++) begin
			c[8 + b].op = op;
			c[8 + b].srcA = 5'(b); // straight from input bit b
		end
		return c;
	endfunction

	function automatic chrom_t forwardChrom();
		chrom_t c;
		c = '0;
		for (int k = 0; k < `EVO_NUM_GENES; k++) begin
			c[k].op = geneOp_e'(k % 8);
			if (k % 2 == 0) begin
				c[k].srcA = 5'(8 + k); // own node
				c[k].srcB = (k % 4 == 0) ? 5'(9 + k) : 5'(k % 8); // later node or input
			end else begin
				c[k].srcA = 5'(k - 1);
				c[k].srcB = 5'(24 + k % 8); // past the last node
			end
		end
		return c;
	endfunction

	function automatic chrom_t randomChrom();
		chrom_t c;
		for (int k = 0; k < `EVO_NUM_GENES; k++) begin
			c[k] = geneWord_t'(16'($random(seed)));
		end
		return c;
	endfunction

	task automatic abortRun(input string why);
		$display("run stopped at %0t: %s", $time, why);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic waitCredit();
		int cyc;
		cyc = 0;
		while (credits == 0 && cyc < WaitLimit) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (credits == 0) begin
			abortRun("no credit came back in time");
		end
	endtask

	task automatic waitDone();
		int cyc;
		cyc = 0;
		while (!done && cyc < WaitLimit) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (!done) begin
			abortRun("done never came");
		end else begin
			@(posedge clk); // sums are checked on this edge
			#1;
		end
	endtask

	task automatic expectSums(input errorSums_t want, input string what);
		assert (errorSums == want) else begin
			errCount++;
			$display("CHECK FAILED at %0t: errorSums (%s) got %h expected %h", $time, what,
				errorSums, want);
		end
	endtask

	task automatic expectCount(input string name, input int got, input int want);
		assert (got == want) else begin
			errCount++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic startRun(input chrom_t c);
		start = 1'b1;
		chrom = c;
		modelChrom = c;
		expSums = '0;
		maskTally = '0;
		@(posedge clk);
		#1;
		start = 1'b0;
		expectSums('0, "cleared by start");
	endtask

	task automatic sendSample(input sample_t s);
		logic [`EVO_OUT_BITS-1:0] out;
		waitCredit();
		sampleValid = 1'b1;
		sampleIn = s;
		out = modelOut(modelChrom, s.inSeq);
		for (int b = 0; b < `EVO_OUT_BITS; b++) begin
			if (s.validMask[b] && out[b] != s.expected[b]) begin
				expSums[b] = expSums[b] + 16'd1;
			end
			maskTally[b] = maskTally[b] + 16'(s.validMask[b]);
		end
		@(posedge clk);
		#1;
		sampleValid = 1'b0;
	endtask

	// kind 0 expected = input with full mask, 1 random mask, 2 all random
	task automatic streamSamples(input int n, input int kind);
		sample_t s;
		for (int i = 0; i < n; i++) begin
			s.inSeq = 8'($random(seed));
			s.expected = (kind == 2) ? 8'($random(seed)) : s.inSeq;
			s.validMask = (kind == 0) ? 8'hff : 8'($random(seed));
			s.last = (i == n - 1);
			sendSample(s);
		end
		waitDone();
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testCount++;
		$display("test %s: %s", name, (errCount == errBefore) ? "ok" : "failed");
	endtask

	initial begin
		int errBefore;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		chrom = '0;
		sampleValid = 1'b0;
		sampleIn = '0;
		modelChrom = '0; // matches the reset chromosome
		expSums = '0;
		maskTally = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		errBefore = errCount; // four back-to-back samples on fresh credits
		streamSamples(Depth, 2);
		expectCount("credits returned", returnedTotal, sentTotal);
		expectCount("credits", credits, Depth);
		finishTest("credit flow", errBefore);

		errBefore = errCount;
		startRun(gateBank(opPassA));
		streamSamples(8, 0);
		expectSums('0, "identity");
		finishTest("identity circuit", errBefore);

		errBefore = errCount;
		startRun(gateBank(opNotA));
		streamSamples(10, 1);
		expectSums(maskTally, "inverted"); // every masked bit is wrong
		finishTest("inverted circuit", errBefore);

		errBefore = errCount;
		startRun(forwardChrom());
		streamSamples(12, 2);
		finishTest("forward references", errBefore);

		errBefore = errCount;
		for (int run = 0; run < 5; run++) begin
			startRun(randomChrom()); // also checks the clear
			streamSamples(3 + 2 * run, 2);
		end
		finishTest("random chromosomes", errBefore);

		$display("tests run %0d, failed checks %0d", testCount, errCount);
		if (errCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/evo_pkg.sv
design/sampleBuffer.sv
design/chromDecode.sv
design/circuitEval.sv
design/errorAccum.sv
design/evolveEvalTop.sv
tests/tb_evolveEvalTop.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_evolveEvalTop
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= ERRORS FOUND
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(wildcard include/*.svh design/*.sv tests/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) compile.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f --Mdir $(BUILD_DIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
